// ==== build.f ====
+incdir+source
source/game_pkg.sv
source/game_sprite.sv
source/game_overlap.sv
source/game_master_fsm.sv
source/game_end_timer.sv
source/game_top.sv
sim/game_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the game testbench with Verilator, then run it.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f build.f \
    --top-module game_tb \
    -Mdir obj_dir \
    -o game_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/game_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

exit 0

// ==== sim/game_tb.sv ====
`timescale 1ns/1ns

`include "game_defines.svh"

module game_tb;

    localparam int clk_period  = 4;
    localparam int tick_gap    = 4;   // idle cycles after each frame tick.
    localparam int max_ticks   = 64;
    localparam int game_cycles = 31 * (tick_gap + 2) + `END_TIMER_CYCLES + 24;
    localparam int watchdog_ns = 2 * clk_period * (3 * game_cycles + 40);

    logic             clk = 1'b0;
    logic             reset;
    logic             launch_key;
    logic             frame_tick;

    game_pkg::coord_t target_x;
    game_pkg::coord_t target_y;
    game_pkg::coord_t torpedo_x;
    game_pkg::coord_t torpedo_y;
    logic             collision;
    logic             game_won;
    logic             game_over;

    int               ticks_total;  // frame ticks this game.
    int               ticks_shot;   // frame ticks since launch.
    bit               launched;
    bit               game_ended;
    bit               game_hit;

    game_top UUT
    (
        .clk        (clk),
        .reset      (reset),
        .launch_key (launch_key),
        .frame_tick (frame_tick),
        .target_x   (target_x),
        .target_y   (target_y),
        .torpedo_x  (torpedo_x),
        .torpedo_y  (torpedo_y),
        .collision  (collision),
        .game_won   (game_won),
        .game_over  (game_over)
    );

    always #(clk_period / 2) clk = ~clk;

    // ==================================================
    // reference model
    // ==================================================

    function automatic int sprite_pos(input int start, input int vel, input int ticks);
        return start + vel * ticks;
    endfunction

    function automatic bit fits_screen(input int x, input int y);
        return (x >= 0) && (y >= 0)
            && (x + `SPRITE_W <= `SCREEN_W) && (y + `SPRITE_H <= `SCREEN_H);
    endfunction

    // gap between two boxes on one axis is zero or less when they touch.
    function automatic int axis_gap(input int a, input int b, input int size);
        return ((a > b) ? a - b : b - a) - size + 1;
    endfunction

    function automatic bit boxes_overlap(input int tx, input int ty, input int px,
                                         input int py);
        return (axis_gap(tx, px, `SPRITE_W) <= 0) && (axis_gap(ty, py, `SPRITE_H) <= 0);
    endfunction

    // smallest box separation over a game launched after k0 ticks.
    function automatic int closest_pass(input int k0);
        int m;
        int tx;
        int ty;
        int px;
        int py;
        int sep;
        int best;
        best = 1 << 20;
        for (m = 1; m <= max_ticks; m++)
        begin
            tx  = sprite_pos(`TARGET_START_X, `TARGET_DX, k0 + m);
            ty  = sprite_pos(`TARGET_START_Y, `TARGET_DY, k0 + m);
            px  = sprite_pos(`TORPEDO_START_X, `TORPEDO_DX, m);
            py  = sprite_pos(`TORPEDO_START_Y, `TORPEDO_DY, m);
            sep = axis_gap(tx, px, `SPRITE_W);
            if (axis_gap(ty, py, `SPRITE_H) > sep)
                sep = axis_gap(ty, py, `SPRITE_H);
            if (sep < best)
                best = sep;
            if (sep <= 0 || !fits_screen(tx, ty) || !fits_screen(px, py))
                break;
        end
        return best;
    endfunction

    function automatic int best_launch_tick();
        int k;
        int sep;
        int best_sep;
        int best_tick;
        best_sep  = 1 << 20;
        best_tick = 0;
        for (k = 0; k <= max_ticks; k++)
        begin
            if (!fits_screen(sprite_pos(`TARGET_START_X, `TARGET_DX, k),
                             sprite_pos(`TARGET_START_Y, `TARGET_DY, k)))
                break;
            sep = closest_pass(k);
            if (sep < best_sep)
            begin
                best_sep  = sep;
                best_tick = k;
            end
        end
        return best_tick;
    endfunction

    // ==================================================
    // checks
    // ==================================================

    task automatic compare_coord(input string what, input game_pkg::coord_t got,
                                 input game_pkg::coord_t exp);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "coordinate mismatch");
        end
    endtask

    task automatic compare_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic compare_count(input string what, input int got, input int exp);
        if (got != exp)
        begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    // ==================================================
    // stimulus
    // ==================================================

    task automatic pulse_tick();
        frame_tick = 1'b1;
        @(negedge clk);
        frame_tick = 1'b0;
    endtask

    task automatic press_launch();
        launch_key = 1'b1;
        @(negedge clk);
        launch_key = 1'b0;
        repeat (3) @(negedge clk);  // torpedo velocity loaded by now.
        launched = 1'b1;
    endtask

    // one tick, then positions and flags against the model.
    task automatic advance_tick();
        int tx;
        int ty;
        int px;
        int py;
        pulse_tick();
        ticks_total++;
        if (launched)
            ticks_shot++;
        tx = sprite_pos(`TARGET_START_X, `TARGET_DX, ticks_total);
        ty = sprite_pos(`TARGET_START_Y, `TARGET_DY, ticks_total);
        px = sprite_pos(`TORPEDO_START_X, `TORPEDO_DX, ticks_shot);
        py = sprite_pos(`TORPEDO_START_Y, `TORPEDO_DY, ticks_shot);
        compare_coord("target_x", target_x, game_pkg::coord_t'(tx));
        compare_coord("target_y", target_y, game_pkg::coord_t'(ty));
        compare_coord("torpedo_x", torpedo_x, game_pkg::coord_t'(px));
        compare_coord("torpedo_y", torpedo_y, game_pkg::coord_t'(py));
        game_hit   = boxes_overlap(tx, ty, px, py);
        game_ended = game_hit || !fits_screen(tx, ty) || !fits_screen(px, py);
        if (!game_ended)
        begin
            repeat (tick_gap) @(negedge clk);
            compare_bit("collision", collision, 1'b0);
            compare_bit("game_won", game_won, 1'b0);
            compare_bit("game_over", game_over, 1'b0);
        end
    endtask

    task automatic play_game(input bit do_launch, input int launch_tick);
        while (!game_ended)
        begin
            if (ticks_total >= max_ticks)
                stop_run("the game did not end within the expected number of frame ticks");
            if (do_launch && !launched && ticks_total == launch_tick)
                press_launch();
            advance_tick();
        end
    endtask

    // pause length and result flags once the game has ended.
    task automatic finish_game(input bit exp_won);
        int waited;
        int high;
        waited = 0;
        while (game_over !== 1'b1)
        begin
            if (waited == 8)
                stop_run("game_over never rose after the game ended");
            @(negedge clk);
            waited++;
        end
        high = 0;
        while (game_over === 1'b1)
        begin
            compare_bit("game_won", game_won, exp_won);
            compare_bit("collision", collision, exp_won);
            high++;
            if (high > `END_TIMER_CYCLES + 4)
                stop_run("game_over stayed high far past the end-of-game pause");
            @(negedge clk);
        end
        compare_count("game_over cycles", high, `END_TIMER_CYCLES);
    endtask

    // start positions back within 3 cycles, then clean flags.
    task automatic wait_game_start();
        int waited;
        waited = 0;
        while (!(target_x == `TARGET_START_X && target_y == `TARGET_START_Y
                 && torpedo_x == `TORPEDO_START_X && torpedo_y == `TORPEDO_START_Y))
        begin
            if (waited == 3)
                stop_run("sprites did not return to their start positions");
            @(negedge clk);
            waited++;
        end
        repeat (3) @(negedge clk);  // stale collision flushes out.
        compare_coord("target_x", target_x, `TARGET_START_X);
        compare_coord("target_y", target_y, `TARGET_START_Y);
        compare_coord("torpedo_x", torpedo_x, `TORPEDO_START_X);
        compare_coord("torpedo_y", torpedo_y, `TORPEDO_START_Y);
        compare_bit("game_won", game_won, 1'b0);
        compare_bit("collision", collision, 1'b0);
        compare_bit("game_over", game_over, 1'b0);
        ticks_total = 0;
        ticks_shot  = 0;
        launched    = 1'b0;
        game_ended  = 1'b0;
        game_hit    = 1'b0;
    endtask

    // ==================================================
    // directed tests
    // ==================================================

    task automatic test_start_state();
        wait_game_start();
    endtask

    task automatic test_aim_motion();
        repeat (5) advance_tick();  // target only.
    endtask

    task automatic test_miss_by_edge();
        play_game(1'b0, 0);
        finish_game(1'b0);
        wait_game_start();
    endtask

    task automatic test_hit();
        int k0;
        k0 = best_launch_tick();
        $display("launch after %0d ticks, closest pass %0d pixels", k0, closest_pass(k0));
        play_game(1'b1, k0);
        finish_game(game_hit);
        wait_game_start();
    endtask

    task automatic test_torpedo_miss();
        int k0;
        k0 = $urandom % 10;  // early enough that the torpedo leaves first.
        play_game(1'b1, k0);
        finish_game(1'b0);
        wait_game_start();
    endtask

    initial
    begin
        #(watchdog_ns);
        $display("simulation timed out before the tests completed");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        reset      = 1'b1;
        launch_key = 1'b0;
        frame_tick = 1'b0;
        void'($urandom(32'h3262ac8d));
        repeat (3) @(negedge clk);
        reset = 1'b0;

        test_start_state();
        test_aim_motion();
        test_miss_by_edge();
        test_hit();
        test_torpedo_miss();

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== source/game_top.sv ====
`timescale 1ns/1ns

`include "game_defines.svh"

module game_top
(
    input  logic             clk,
    input  logic             reset,

    input  logic             launch_key,
    input  logic             frame_tick,

    output game_pkg::coord_t target_x,
    output game_pkg::coord_t target_y,
    output game_pkg::coord_t torpedo_x,
    output game_pkg::coord_t torpedo_y,

    output logic             collision,
    output logic             game_won,
    output logic             game_over
);

    logic [game_pkg::n_sprites-1:0] write_xy;
    logic [game_pkg::n_sprites-1:0] write_dxy;
    logic [game_pkg::n_sprites-1:0] enable_update;
    logic [game_pkg::n_sprites-1:0] within_screen;

    game_pkg::coord_t               sprite_x [game_pkg::n_sprites];
    game_pkg::coord_t               sprite_y [game_pkg::n_sprites];

    logic                           end_of_game_timer_start;
    logic                           end_of_game_timer_running;

    // ==================================================
    // control
    // ==================================================

    game_master_fsm u_fsm
    (
        .clk                       (clk),
        .reset                     (reset),
        .launch_key                (launch_key),
        .within_screen             (within_screen),
        .collision                 (collision),
        .end_of_game_timer_running (end_of_game_timer_running),
        .write_xy                  (write_xy),
        .write_dxy                 (write_dxy),
        .enable_update             (enable_update),
        .end_of_game_timer_start   (end_of_game_timer_start),
        .game_won                  (game_won)
    );

    // ==================================================
    // sprite engines
    // ==================================================

    for (genvar i = 0; i < game_pkg::n_sprites; i++)
    begin : g_sprite
        localparam bit is_target = (i == game_pkg::sprite_target);

        game_sprite
        #(
            .START_X (is_target ? `TARGET_START_X : `TORPEDO_START_X),
            .START_Y (is_target ? `TARGET_START_Y : `TORPEDO_START_Y),
            .DX      (is_target ? `TARGET_DX      : `TORPEDO_DX),
            .DY      (is_target ? `TARGET_DY      : `TORPEDO_DY)
        )
        u_sprite
        (
            .clk           (clk),
            .reset         (reset),
            .frame_tick    (frame_tick),
            .write_xy      (write_xy[i]),
            .write_dxy     (write_dxy[i]),
            .enable_update (enable_update[i]),
            .x             (sprite_x[i]),
            .y             (sprite_y[i]),
            .within_screen (within_screen[i])
        );
    end

    assign target_x  = sprite_x[game_pkg::sprite_target];
    assign target_y  = sprite_y[game_pkg::sprite_target];
    assign torpedo_x = sprite_x[game_pkg::sprite_torpedo];
    assign torpedo_y = sprite_y[game_pkg::sprite_torpedo];

    game_overlap u_overlap
    (
        .clk       (clk),
        .reset     (reset),
        .target_x  (target_x),
        .target_y  (target_y),
        .torpedo_x (torpedo_x),
        .torpedo_y (torpedo_y),
        .collision (collision)
    );

    game_end_timer u_end_timer
    (
        .clk     (clk),
        .reset   (reset),
        .start   (end_of_game_timer_start),
        .running (end_of_game_timer_running)
    );

    assign game_over = end_of_game_timer_running;  // high through the pause.

endmodule

// ==== source/game_end_timer.sv ====
`timescale 1ns/1ns

`include "game_defines.svh"

module game_end_timer
(
    input  logic clk,
    input  logic reset,

    input  logic start,
    output logic running
);

    localparam int count_w = $clog2(`END_TIMER_CYCLES + 1);

    logic [count_w-1:0] count;

    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (start)
            count <= count_w'(`END_TIMER_CYCLES);  // restart from full length.
        else if (count != '0)
            count <= count - 1'b1;
    end

    assign running = (count != '0);

endmodule

// ==== source/game_master_fsm.sv ====
`timescale 1ns/1ns

module game_master_fsm
(
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         launch_key,

    input  logic [game_pkg::n_sprites-1:0] within_screen,
    input  logic                         collision,
    input  logic                         end_of_game_timer_running,

    output logic [game_pkg::n_sprites-1:0] write_xy,
    output logic [game_pkg::n_sprites-1:0] write_dxy,
    output logic [game_pkg::n_sprites-1:0] enable_update,

    output logic                         end_of_game_timer_start,
    output logic                         game_won
);

    // one-hot state bit positions.
    localparam int state_start = 0;
    localparam int state_aim   = 1;
    localparam int state_shoot = 2;
    localparam int state_end   = 3;

    logic [3:0]                     state;
    logic [3:0]                     d_state;

    logic [game_pkg::n_sprites-1:0] d_write_xy;
    logic [game_pkg::n_sprites-1:0] d_write_dxy;
    logic [game_pkg::n_sprites-1:0] d_enable_update;
    logic                           d_end_of_game_timer_start;
    logic                           d_game_won;

    logic                           load_settle;  // write_xy seen last cycle.
    logic                           end_of_game;

    // ==================================================
    // end condition
    // ==================================================

    // positions land one cycle after write_xy and collision one more,
    // so stale values from the last game are ignored meanwhile.
    assign end_of_game = (~&within_screen | collision)
                       & ~write_xy[game_pkg::sprite_target]
                       & ~load_settle;

    always_comb
    begin
        d_state                   = '0;
        d_write_xy                = '0;
        d_write_dxy               = '0;
        d_enable_update           = '0;
        d_end_of_game_timer_start = 1'b0;
        d_game_won                = game_won;

        case (1'b1)
            state[state_start]:
            begin
                d_write_xy                            = '1;  // both sprites.
                d_write_dxy[game_pkg::sprite_target]  = 1'b1;
                d_game_won                            = 1'b0;
                d_state[state_aim]                    = 1'b1;
            end

            state[state_aim]:
            begin
                d_enable_update[game_pkg::sprite_target] = 1'b1;

                if (end_of_game)
                begin
                    d_end_of_game_timer_start = 1'b1;
                    d_state[state_end]        = 1'b1;
                end
                else if (launch_key)
                    d_state[state_shoot] = 1'b1;
                else
                    d_state[state_aim]   = 1'b1;
            end

            state[state_shoot]:
            begin
                d_write_dxy[game_pkg::sprite_torpedo] = 1'b1;
                d_enable_update                       = '1;

                if (collision)
                    d_game_won = 1'b1;

                if (end_of_game)
                begin
                    d_end_of_game_timer_start = 1'b1;
                    d_state[state_end]        = 1'b1;
                end
                else
                    d_state[state_shoot] = 1'b1;
            end

            state[state_end]:
            begin
                // collision is registered, so a hit may show up here first.
                if (collision)
                    d_game_won = 1'b1;

                // timer only reports running a cycle after its start pulse.
                if (!end_of_game_timer_running && !end_of_game_timer_start)
                    d_state[state_start] = 1'b1;
                else
                    d_state[state_end]   = 1'b1;
            end

            default:
                d_state[state_start] = 1'b1;  // recover from an illegal code.
        endcase
    end

    // ==================================================
    // state and registered outputs
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state                   <= 4'b1 << state_start;
            write_xy                <= '0;
            write_dxy               <= '0;
            enable_update           <= '0;
            end_of_game_timer_start <= 1'b0;
            game_won                <= 1'b0;
            load_settle             <= 1'b0;
        end
        else
        begin
            state                   <= d_state;
            write_xy                <= d_write_xy;
            write_dxy               <= d_write_dxy;
            enable_update           <= d_enable_update;
            end_of_game_timer_start <= d_end_of_game_timer_start;
            game_won                <= d_game_won;
            load_settle             <= write_xy[game_pkg::sprite_target];
        end
    end

endmodule

// ==== source/game_overlap.sv ====
`timescale 1ns/1ns

`include "game_defines.svh"

module game_overlap
(
    input  logic             clk,
    input  logic             reset,

    input  game_pkg::coord_t target_x,
    input  game_pkg::coord_t target_y,
    input  game_pkg::coord_t torpedo_x,
    input  game_pkg::coord_t torpedo_y,

    output logic             collision
);

    // one extra bit so the difference of two coordinates cannot wrap.
    logic signed [10:0] diff_x;
    logic signed [10:0] diff_y;
    logic signed [10:0] abs_x;
    logic signed [10:0] abs_y;

    always_comb
    begin
        diff_x = 11'(target_x) - 11'(torpedo_x);
        diff_y = 11'(target_y) - 11'(torpedo_y);

        abs_x  = diff_x < 0 ? -diff_x : diff_x;
        abs_y  = diff_y < 0 ? -diff_y : diff_y;
    end

    // ==================================================
    // registered bounding-box test
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
            collision <= 1'b0;
        else
            collision <= (abs_x < `SPRITE_W) && (abs_y < `SPRITE_H);
    end

endmodule

// ==== source/game_sprite.sv ====
`timescale 1ns/1ns

`include "game_defines.svh"

module game_sprite
#(
    parameter int START_X = 0,
    parameter int START_Y = 0,
    parameter int DX      = 0,
    parameter int DY      = 0
)
(
    input  logic             clk,
    input  logic             reset,

    input  logic             frame_tick,

    input  logic             write_xy,
    input  logic             write_dxy,
    input  logic             enable_update,

    output game_pkg::coord_t x,
    output game_pkg::coord_t y,

    output logic             within_screen
);

    game_pkg::coord_t dx;
    game_pkg::coord_t dy;

    // ==================================================
    // position and velocity
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            x  <= '0;
            y  <= '0;
            dx <= '0;
            dy <= '0;
        end
        else
        begin
            if (write_xy)
            begin
                x  <= game_pkg::coord_t'(START_X);
                y  <= game_pkg::coord_t'(START_Y);
                dx <= '0;  // sprite parks until launched.
                dy <= '0;
            end
            else if (enable_update && frame_tick)
            begin
                x <= x + dx;
                y <= y + dy;
            end

            // a velocity load in the same cycle as write_xy wins.
            if (write_dxy)
            begin
                dx <= game_pkg::coord_t'(DX);
                dy <= game_pkg::coord_t'(DY);
            end
        end
    end

    // ==================================================
    // screen bounds
    // ==================================================

    // whole box must lie inside; negative coordinates are off screen.
    always_comb
    begin
        within_screen = (x >= 0)
                     && (y >= 0)
                     && (x + `SPRITE_W <= `SCREEN_W)
                     && (y + `SPRITE_H <= `SCREEN_H);
    end

endmodule

// ==== source/game_pkg.sv ====
package game_pkg;

    // signed so a sprite left of or above the screen stays visible as negative.
    typedef logic signed [9:0] coord_t;

    // sprite slots, also used as generate and vector indices.
    typedef enum int
    {
        sprite_target  = 0,
        sprite_torpedo = 1
    } sprite_id_t;

    localparam int n_sprites = 2;

endpackage

// ==== source/game_defines.svh ====
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// ==================================================
// screen and sprite geometry
// ==================================================

`define SCREEN_W           64  // visible width in pixels.
`define SCREEN_H           48  // visible height in pixels.

`define SPRITE_W           4
`define SPRITE_H           4

// ==================================================
// launch values per sprite
// ==================================================

`define TARGET_START_X     0
`define TARGET_START_Y     4
`define TARGET_DX          2   // slides right.
`define TARGET_DY          0

`define TORPEDO_START_X    30
`define TORPEDO_START_Y    40
`define TORPEDO_DX         0
`define TORPEDO_DY         (-2) // climbs toward the top edge.

// pause between games, in clock cycles.
`define END_TIMER_CYCLES   16

`endif
